// File: include/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Cache geometry
`define CACHE_NUM_SETS   64
`define CACHE_NUM_WAYS   4
`define CACHE_LINE_BYTES 16

// Bus widths in bits
`define CACHE_ADDR_W     32
`define CACHE_DATA_W     32

`endif

// File: hw/cache_pkg.sv
package cache_pkg;

    `include "cache_settings.svh"

    localparam int BYTE_OFF_W     = $clog2(`CACHE_DATA_W / 8);
    localparam int INDEX_W        = $clog2(`CACHE_NUM_SETS);
    localparam int OFFSET_W       = $clog2(`CACHE_LINE_BYTES);
    localparam int TAG_W          = `CACHE_ADDR_W - INDEX_W - OFFSET_W;
    localparam int WAY_W          = $clog2(`CACHE_NUM_WAYS);
    localparam int WORD_SEL_W     = OFFSET_W - BYTE_OFF_W;
    localparam int WORDS_PER_LINE = `CACHE_LINE_BYTES / (`CACHE_DATA_W / 8);

    typedef logic [`CACHE_ADDR_W-1:0]     addr_t;
    typedef logic [`CACHE_DATA_W-1:0]     data_t;
    typedef logic [`CACHE_DATA_W/8-1:0]   strb_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [WAY_W-1:0]             way_t;
    typedef logic [WORD_SEL_W-1:0]        word_sel_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        VICTIM,
        WB_REQ,
        WB_WAIT,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } cache_state_e;

    // Carried on mem_req_we
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

// File: hw/cache_ifs.sv
`timescale 1ns/1ps

interface tag_if;
    import cache_pkg::*;

    index_t index;
    tag_t   tag;
    way_t   sel_way;
    logic   fill_we;
    logic   mark_dirty;
    way_t   dirty_way;

    logic   hit;
    way_t   hit_way;
    logic   free_found;
    way_t   free_way;
    logic   sel_valid;
    logic   sel_dirty;
    tag_t   sel_tag;

    modport ctrl (
        output index, tag, sel_way, fill_we, mark_dirty, dirty_way,
        input  hit, hit_way, free_found, free_way, sel_valid, sel_dirty, sel_tag
    );

    modport store (
        input  index, tag, sel_way, fill_we, mark_dirty, dirty_way,
        output hit, hit_way, free_found, free_way, sel_valid, sel_dirty, sel_tag
    );
endinterface

interface data_if;
    import cache_pkg::*;

    index_t    index;
    way_t      way;
    word_sel_t word_sel;
    logic      we;
    data_t     wdata;
    strb_t     wstrb;
    data_t     rdata;

    modport ctrl  (output index, way, word_sel, we, wdata, wstrb, input  rdata);
    modport store (input  index, way, word_sel, we, wdata, wstrb, output rdata);
endinterface

interface lru_if;
    import cache_pkg::*;

    logic   touch;
    index_t index;
    way_t   way;
    way_t   victim_way;

    modport ctrl    (output touch, index, way, input  victim_way);
    modport tracker (input  touch, index, way, output victim_way);
endinterface

// File: hw/tag_store.sv
`timescale 1ns/1ps

`include "cache_settings.svh"

module tag_store (
    input  logic clk,
    input  logic rst_n,
    tag_if.store tags
);
    import cache_pkg::*;

    tag_t                       tag_q   [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    logic [`CACHE_NUM_WAYS-1:0] valid_q [`CACHE_NUM_SETS];
    logic [`CACHE_NUM_WAYS-1:0] dirty_q [`CACHE_NUM_SETS];
    logic [`CACHE_NUM_WAYS-1:0] hit_vec;

    // Tag compare across all ways of the set
    always_comb begin
        tags.hit     = 1'b0;
        tags.hit_way = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            hit_vec[w] = valid_q[tags.index][w] && (tag_q[tags.index][w] == tags.tag);
            if (hit_vec[w]) begin
                tags.hit     = 1'b1;
                tags.hit_way = way_t'(w);
            end
        end
    end

    // Downward scan so the lowest invalid way wins
    always_comb begin
        tags.free_found = 1'b0;
        tags.free_way   = '0;
        for (int w = `CACHE_NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[tags.index][w]) begin
                tags.free_found = 1'b1;
                tags.free_way   = way_t'(w);
            end
        end
    end

    assign tags.sel_valid = valid_q[tags.index][tags.sel_way];
    assign tags.sel_dirty = dirty_q[tags.index][tags.sel_way];
    assign tags.sel_tag   = tag_q[tags.index][tags.sel_way];

    always_ff @(posedge clk) begin
        if (tags.fill_we) begin
            tag_q[tags.index][tags.sel_way] <= tags.tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            if (tags.fill_we) begin
                valid_q[tags.index][tags.sel_way] <= 1'b1;
                dirty_q[tags.index][tags.sel_way] <= 1'b0;
            end
            // Later assignment wins, so a write fill lands dirty
            if (tags.mark_dirty) begin
                dirty_q[tags.index][tags.dirty_way] <= 1'b1;
            end
        end
    end

    // Fills only go to missing tags, so a duplicate means a controller bug
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_vec))
        else $error("tag_store: more than one way hits in set %0d", tags.index);

endmodule

// File: hw/data_store.sv
`timescale 1ns/1ps

`include "cache_settings.svh"

module data_store (
    input  logic  clk,
    data_if.store data
);
    import cache_pkg::*;

    data_t mem_q [`CACHE_NUM_SETS][`CACHE_NUM_WAYS][WORDS_PER_LINE];

    assign data.rdata = mem_q[data.index][data.way][data.word_sel];

    // Byte merge under the strobe, refill words come with all lanes set
    always_ff @(posedge clk) begin
        if (data.we) begin
            for (int b = 0; b < `CACHE_DATA_W / 8; b++) begin
                if (data.wstrb[b]) begin
                    mem_q[data.index][data.way][data.word_sel][b*8 +: 8] <=
                        data.wdata[b*8 +: 8];
                end
            end
        end
    end

    a_write_sel_known: assert property (
        @(posedge clk) data.we |-> !$isunknown({data.index, data.way, data.word_sel})
    ) else $error("data_store: write with unknown way or word select");

endmodule

// File: hw/lru_tracker.sv
`timescale 1ns/1ps

`include "cache_settings.svh"

module lru_tracker (
    input  logic   clk,
    input  logic   rst_n,
    lru_if.tracker lru
);
    import cache_pkg::*;

    typedef way_t [`CACHE_NUM_WAYS-1:0] ages_t;

    ages_t age_q [`CACHE_NUM_SETS];
    ages_t set_ages;

    function automatic logic is_perm(ages_t a);
        logic [`CACHE_NUM_WAYS-1:0] seen;
        seen = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            seen[a[w]] = 1'b1;
        end
        return &seen;
    endfunction

    assign set_ages = age_q[lru.index];

    // Oldest way, lowest index on a tie
    always_comb begin
        lru.victim_way = '0;
        for (int w = 1; w < `CACHE_NUM_WAYS; w++) begin
            if (set_ages[w] > set_ages[lru.victim_way]) begin
                lru.victim_way = way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
                age_q[s] <= '0;
            end
        end else if (lru.touch) begin
            for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                if (way_t'(w) == lru.way) begin
                    age_q[lru.index][w] <= '0;
                end else if (set_ages[w] <= set_ages[lru.way] && set_ages[w] != '1) begin
                    // Untouched ways share the top age until the set fills
                    age_q[lru.index][w] <= set_ages[w] + 1'b1;
                end
            end
        end
    end

    a_ages_perm: assert property (
        @(posedge clk) disable iff (!rst_n)
        lru.touch && is_perm(set_ages) |=> is_perm(age_q[$past(lru.index)])
    ) else $error("lru_tracker: ages of set %0d lost their ordering", $past(lru.index));

endmodule

// File: hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  logic             req_we,
    input  cache_pkg::addr_t req_addr,
    input  cache_pkg::data_t req_wdata,
    input  cache_pkg::strb_t req_wstrb,
    output logic             resp_valid,
    output cache_pkg::data_t resp_rdata,
    output logic             resp_stall,
    output logic             mem_req_valid,
    output logic             mem_req_we,
    output cache_pkg::addr_t mem_req_addr,
    output cache_pkg::data_t mem_req_wdata,
    input  logic             mem_resp_valid,
    input  cache_pkg::data_t mem_resp_rdata,
    output logic             hit_pulse,
    output logic             miss_pulse,
    output logic             dirty_eviction_pulse,
    tag_if.ctrl              tags,
    data_if.ctrl             data,
    lru_if.ctrl              lru
);
    import cache_pkg::*;

    cache_state_e state_q;
    mem_op_e      mem_op_q;

    logic         req_we_q;
    addr_t        req_addr_q;
    data_t        req_wdata_q;
    strb_t        req_wstrb_q;

    way_t         victim_q;
    way_t         active_way_q;
    word_sel_t    cnt_q;

    index_t       req_index;
    tag_t         req_tag;
    word_sel_t    req_word;
    way_t         victim_pick;
    logic         last_word;
    logic         fill_word;
    logic         fill_last;

    assign req_index = req_addr_q[OFFSET_W +: INDEX_W];
    assign req_tag   = req_addr_q[OFFSET_W + INDEX_W +: TAG_W];
    assign req_word  = req_addr_q[BYTE_OFF_W +: WORD_SEL_W];

    // Free way first, LRU only when the set is full
    assign victim_pick = tags.free_found ? tags.free_way : lru.victim_way;

    assign last_word = (cnt_q == word_sel_t'(WORDS_PER_LINE - 1));
    assign fill_word = (state_q == FILL_WAIT) && mem_resp_valid;
    assign fill_last = fill_word && last_word;

    assign tags.index      = req_index;
    assign tags.tag        = req_tag;
    assign tags.sel_way    = (state_q == VICTIM) ? victim_pick : victim_q;
    assign tags.fill_we    = fill_last;
    assign tags.mark_dirty = req_we_q && (fill_last || state_q == RESPOND);
    assign tags.dirty_way  = (state_q == RESPOND) ? active_way_q : victim_q;

    assign data.index    = req_index;
    assign data.way      = (state_q == RESPOND) ? active_way_q : victim_q;
    assign data.word_sel = (state_q == RESPOND) ? req_word : cnt_q;
    assign data.we       = fill_word || (state_q == RESPOND && req_we_q);
    assign data.wdata    = (state_q == RESPOND) ? req_wdata_q : mem_resp_rdata;
    assign data.wstrb    = (state_q == RESPOND) ? req_wstrb_q : '1;

    assign lru.touch = (state_q == LOOKUP && tags.hit) || fill_last;
    assign lru.index = req_index;
    assign lru.way   = (state_q == LOOKUP) ? tags.hit_way : victim_q;

    assign resp_stall = (state_q != IDLE);
    assign mem_req_we = (mem_op_q == MEM_WRITE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q              <= IDLE;
            mem_op_q             <= MEM_READ;
            victim_q             <= '0;
            active_way_q         <= '0;
            cnt_q                <= '0;
            resp_valid           <= 1'b0;
            mem_req_valid        <= 1'b0;
            hit_pulse            <= 1'b0;
            miss_pulse           <= 1'b0;
            dirty_eviction_pulse <= 1'b0;
        end else begin
            resp_valid           <= 1'b0;
            mem_req_valid        <= 1'b0;
            hit_pulse            <= 1'b0;
            miss_pulse           <= 1'b0;
            dirty_eviction_pulse <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (req_valid) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (tags.hit) begin
                        hit_pulse    <= 1'b1;
                        active_way_q <= tags.hit_way;
                        state_q      <= RESPOND;
                    end else begin
                        miss_pulse <= 1'b1;
                        state_q    <= VICTIM;
                    end
                end
                VICTIM: begin
                    victim_q <= victim_pick;
                    cnt_q    <= '0;
                    if (tags.sel_valid && tags.sel_dirty) begin
                        dirty_eviction_pulse <= 1'b1;
                        state_q              <= WB_REQ;
                    end else begin
                        state_q <= FILL_REQ;
                    end
                end
                WB_REQ: begin
                    mem_req_valid <= 1'b1;
                    mem_op_q      <= MEM_WRITE;
                    state_q       <= WB_WAIT;
                end
                WB_WAIT: begin
                    if (mem_resp_valid) begin
                        cnt_q   <= cnt_q + 1'b1;
                        state_q <= last_word ? FILL_REQ : WB_REQ;
                    end
                end
                FILL_REQ: begin
                    mem_req_valid <= 1'b1;
                    mem_op_q      <= MEM_READ;
                    state_q       <= FILL_WAIT;
                end
                FILL_WAIT: begin
                    if (mem_resp_valid) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (last_word) begin
                            active_way_q <= victim_q;
                            state_q      <= RESPOND;
                        end else begin
                            state_q <= FILL_REQ;
                        end
                    end
                end
                RESPOND: begin
                    resp_valid <= 1'b1;
                    state_q    <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_valid) begin
            req_we_q    <= req_we;
            req_addr_q  <= req_addr;
            req_wdata_q <= req_wdata;
            req_wstrb_q <= req_wstrb;
        end
        if (state_q == WB_REQ) begin
            // Victim line address comes from its stored tag
            mem_req_addr  <= {tags.sel_tag, req_index, cnt_q, {BYTE_OFF_W{1'b0}}};
            mem_req_wdata <= data.rdata;
        end
        if (state_q == FILL_REQ) begin
            mem_req_addr <= {req_tag, req_index, cnt_q, {BYTE_OFF_W{1'b0}}};
        end
        if (state_q == RESPOND) begin
            resp_rdata <= req_we_q ? '0 : data.rdata;
        end
    end

    a_mem_req_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) mem_req_valid |=> !mem_req_valid
    ) else $error("cache_ctrl: mem_req_valid held for more than one cycle");

    a_resp_not_mem: assert property (
        @(posedge clk) disable iff (!rst_n) !(resp_valid && mem_req_valid)
    ) else $error("cache_ctrl: response while a memory request is issued");

endmodule

// File: hw/l1_cache_top.sv
`timescale 1ns/1ps

module l1_cache_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  logic             req_we,
    input  cache_pkg::addr_t req_addr,
    input  cache_pkg::data_t req_wdata,
    input  cache_pkg::strb_t req_wstrb,
    output logic             resp_valid,
    output cache_pkg::data_t resp_rdata,
    output logic             resp_stall,
    output logic             mem_req_valid,
    output logic             mem_req_we,
    output cache_pkg::addr_t mem_req_addr,
    output cache_pkg::data_t mem_req_wdata,
    input  logic             mem_resp_valid,
    input  cache_pkg::data_t mem_resp_rdata,
    output logic             hit_pulse,
    output logic             miss_pulse,
    output logic             dirty_eviction_pulse
);

    tag_if  tag_bus ();
    data_if data_bus ();
    lru_if  lru_bus ();

    cache_ctrl u_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .req_valid            (req_valid),
        .req_we               (req_we),
        .req_addr             (req_addr),
        .req_wdata            (req_wdata),
        .req_wstrb            (req_wstrb),
        .resp_valid           (resp_valid),
        .resp_rdata           (resp_rdata),
        .resp_stall           (resp_stall),
        .mem_req_valid        (mem_req_valid),
        .mem_req_we           (mem_req_we),
        .mem_req_addr         (mem_req_addr),
        .mem_req_wdata        (mem_req_wdata),
        .mem_resp_valid       (mem_resp_valid),
        .mem_resp_rdata       (mem_resp_rdata),
        .hit_pulse            (hit_pulse),
        .miss_pulse           (miss_pulse),
        .dirty_eviction_pulse (dirty_eviction_pulse),
        .tags                 (tag_bus.ctrl),
        .data                 (data_bus.ctrl),
        .lru                  (lru_bus.ctrl)
    );

    tag_store u_tag_store (
        .clk   (clk),
        .rst_n (rst_n),
        .tags  (tag_bus.store)
    );

    data_store u_data_store (
        .clk  (clk),
        .data (data_bus.store)
    );

    lru_tracker u_lru_tracker (
        .clk   (clk),
        .rst_n (rst_n),
        .lru   (lru_bus.tracker)
    );

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release on a falling edge after 8 full cycles
    initial begin
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

// File: sim/tb_l1_cache.sv
`timescale 1ns/1ps

module tb_l1_cache;
    import cache_pkg::*;

    localparam int    TIMEOUT_CYCLES = 200;
    localparam data_t INIT_PATTERN   = 32'h5a5a5a5a;

    logic  clk;
    logic  rst_n;
    logic  req_valid;
    logic  req_we;
    addr_t req_addr;
    data_t req_wdata;
    strb_t req_wstrb;
    logic  resp_valid;
    data_t resp_rdata;
    logic  resp_stall;
    logic  mem_req_valid;
    logic  mem_req_we;
    addr_t mem_req_addr;
    data_t mem_req_wdata;
    logic  mem_resp_valid;
    data_t mem_resp_rdata;
    logic  hit_pulse;
    logic  miss_pulse;
    logic  dirty_eviction_pulse;

    integer seed;
    int     errors = 0;
    int     cyc = 0;
    int     hit_cnt = 0;
    int     miss_cnt = 0;
    int     dirty_cnt = 0;
    int     hit_base;
    int     miss_base;
    int     dirty_base;
    int     last_latency;

    data_t  mem_words [addr_t];
    data_t  shadow    [addr_t];
    data_t  exp_q     [$];
    addr_t  log_addr  [$];
    logic   log_we    [$];
    data_t  log_wdata [$];

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    l1_cache_top uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .req_valid            (req_valid),
        .req_we               (req_we),
        .req_addr             (req_addr),
        .req_wdata            (req_wdata),
        .req_wstrb            (req_wstrb),
        .resp_valid           (resp_valid),
        .resp_rdata           (resp_rdata),
        .resp_stall           (resp_stall),
        .mem_req_valid        (mem_req_valid),
        .mem_req_we           (mem_req_we),
        .mem_req_addr         (mem_req_addr),
        .mem_req_wdata        (mem_req_wdata),
        .mem_resp_valid       (mem_resp_valid),
        .mem_resp_rdata       (mem_resp_rdata),
        .hit_pulse            (hit_pulse),
        .miss_pulse           (miss_pulse),
        .dirty_eviction_pulse (dirty_eviction_pulse)
    );

    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Cache is transparent, so reads match the shadow memory
    function automatic data_t expected_read(addr_t addr);
        addr_t key;
        key = addr & ~addr_t'(3);
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return key ^ INIT_PATTERN;
    endfunction

    task automatic check_data(data_t got, data_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pulse(int got, int exp, string what);
        if (got != exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic abort_run(string what);
        errors++;
        $display("Timeout after %0d cycles: %s", TIMEOUT_CYCLES, what);
        finish_run();
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Event counts and response compare
    always @(negedge clk) begin
        if (rst_n) begin
            if (hit_pulse) begin
                hit_cnt++;
            end
            if (miss_pulse) begin
                miss_cnt++;
            end
            if (dirty_eviction_pulse) begin
                dirty_cnt++;
            end
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Response arrived with no request outstanding at %0t", $time);
                end else begin
                    check_data(resp_rdata, exp_q.pop_front(), "response data");
                end
            end
        end
    end

    // Memory model, one request at a time
    initial begin
        int    delay;
        addr_t addr;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req_valid) begin
                addr = mem_req_addr;
                log_addr.push_back(addr);
                log_we.push_back(mem_req_we);
                log_wdata.push_back(mem_req_wdata);
                if (mem_req_we) begin
                    mem_words[addr] = mem_req_wdata;
                end
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                #1;
                mem_resp_valid = 1'b1;
                mem_resp_rdata = mem_words.exists(addr) ? mem_words[addr] : addr ^ INIT_PATTERN;
                @(posedge clk);
                #1;
                mem_resp_valid = 1'b0;
            end
        end
    end

    task automatic take_snapshot();
        hit_base   = hit_cnt;
        miss_base  = miss_cnt;
        dirty_base = dirty_cnt;
        log_addr.delete();
        log_we.delete();
        log_wdata.delete();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (resp_stall) begin
            if (n == TIMEOUT_CYCLES) begin
                abort_run("cache stayed busy");
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic cpu_access(logic we, addr_t addr, data_t wdata, strb_t strb);
        int    start;
        int    n;
        addr_t key;
        wait_idle();
        key = addr & ~addr_t'(3);
        if (we) begin
            shadow[key] = merge_bytes(expected_read(addr), wdata, strb);
            exp_q.push_back('0);
        end else begin
            exp_q.push_back(expected_read(addr));
        end
        req_valid = 1'b1;
        req_we    = we;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        @(posedge clk);
        #1;
        start     = cyc;
        req_valid = 1'b0;
        n = 0;
        while (!resp_valid) begin
            check_pulse(int'(resp_stall), 1, "stall while request in flight");
            if (n == TIMEOUT_CYCLES) begin
                abort_run("no response to a CPU request");
            end
            @(posedge clk);
            #1;
            n++;
        end
        check_pulse(int'(resp_stall), 0, "stall in response cycle");
        last_latency = cyc - start;
        @(posedge clk);
        #1;
    endtask

    // Four memory transfers of one line, starting at log entry first
    task automatic check_line_traffic(int first, logic we, addr_t base);
        if (log_addr.size() < first + WORDS_PER_LINE) begin
            errors++;
            $display("Too few memory requests for line %h at %0t", base, $time);
        end else begin
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
                check_addr(log_addr[first+i], base + addr_t'(4 * i), "memory address");
                check_pulse(int'(log_we[first+i]), int'(we), "memory opcode");
                if (we) begin
                    check_data(log_wdata[first+i], expected_read(base + addr_t'(4 * i)),
                               "writeback data");
                end
            end
        end
    endtask

    initial begin
        addr_t  lines [5];
        addr_t  addr;
        integer r;
        int     n;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        seed      = 32'hbc3cab69;
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n == TIMEOUT_CYCLES) begin
                abort_run("reset never released");
            end
            @(posedge clk);
            #1;
            n++;
        end

        // Cold read
        take_snapshot();
        cpu_access(1'b0, 32'h0000_1234, '0, '0);
        check_pulse(miss_cnt - miss_base, 1, "cold read misses");
        check_pulse(hit_cnt - hit_base, 0, "cold read hits");
        check_pulse(log_addr.size(), WORDS_PER_LINE, "cold read memory requests");
        check_line_traffic(0, 1'b0, 32'h0000_1230);

        // Hit on the same line
        take_snapshot();
        cpu_access(1'b0, 32'h0000_1238, '0, '0);
        check_pulse(hit_cnt - hit_base, 1, "repeat read hits");
        check_pulse(miss_cnt - miss_base, 0, "repeat read misses");
        check_pulse(log_addr.size(), 0, "repeat read memory requests");
        check_pulse(last_latency, 2, "hit latency in cycles");

        // Partial write then read back
        take_snapshot();
        cpu_access(1'b1, 32'h0000_1234, 32'hdead_beef, 4'b0101);
        cpu_access(1'b0, 32'h0000_1234, '0, '0);
        check_pulse(hit_cnt - hit_base, 2, "partial write hits");
        check_pulse(log_addr.size(), 0, "partial write memory requests");

        // Fill one set with dirty lines, then touch L2 first so it ages out
        for (int k = 0; k < 5; k++) begin
            lines[k] = 32'h0004_0050 + addr_t'(k) * 32'h400;
        end
        for (int k = 0; k < 4; k++) begin
            cpu_access(1'b1, lines[k] + addr_t'(4 * k), 32'hc0de_0000 + k, 4'hf);
        end
        cpu_access(1'b0, lines[2], '0, '0);
        cpu_access(1'b0, lines[0], '0, '0);
        cpu_access(1'b0, lines[3], '0, '0);
        cpu_access(1'b0, lines[1], '0, '0);
        take_snapshot();
        cpu_access(1'b1, lines[4], 32'h4444_4444, 4'hf);
        check_pulse(miss_cnt - miss_base, 1, "eviction misses");
        check_pulse(dirty_cnt - dirty_base, 1, "dirty evictions");
        check_pulse(log_addr.size(), 2 * WORDS_PER_LINE, "eviction memory requests");
        check_line_traffic(0, 1'b1, lines[2]);
        check_line_traffic(WORDS_PER_LINE, 1'b0, lines[4]);
        cpu_access(1'b0, lines[2] + 32'h8, '0, '0);

        // Random traffic over 8 tags and 2 sets
        take_snapshot();
        for (int i = 0; i < 300; i++) begin
            r    = $random(seed);
            addr = addr_t'(r) & 32'h0000_1c1c;
            cpu_access(r[20], addr, data_t'($random(seed)), r[27:24]);
        end
        check_pulse((hit_cnt - hit_base) + (miss_cnt - miss_base), 300,
                    "random hits plus misses");

        finish_run();
    end
endmodule

// File: flist.f
+incdir+include
hw/cache_pkg.sv
hw/cache_ifs.sv
hw/tag_store.sv
hw/data_store.sv
hw/lru_tracker.sv
hw/cache_ctrl.sv
hw/l1_cache_top.sv
sim/tb_clock_gen.sv
sim/tb_l1_cache.sv
